//--- overlay_cfg_pkg.sv
package overlay_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Array size
    ////////////////////////////////////////////////////////////////////////////

    // Number of PEs, also the number of beats in one frame
    localparam int PE_NUM = 4;

    // Beat counters index one frame
    localparam int BEAT_CNT_WIDTH = $clog2(PE_NUM);

    ////////////////////////////////////////////////////////////////////////////
    // Fixed point format
    ////////////////////////////////////////////////////////////////////////////

    // Q1.15 for each real and imaginary part
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_BITS  = 15;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////////////////////

    localparam int OP_WIDTH = 2;

    // One opcode field per PE, field i at bits i*OP_WIDTH upward
    localparam int INST_WIDTH = PE_NUM * OP_WIDTH;

endpackage

//--- overlay_types_pkg.sv
package overlay_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Complex sample
    ////////////////////////////////////////////////////////////////////////////

    // Real part sits in the upper half of the 32-bit word
    typedef struct packed {
        logic signed [overlay_cfg_pkg::DATA_WIDTH-1:0] re;
        logic signed [overlay_cfg_pkg::DATA_WIDTH-1:0] im;
    } cplx_t;

    ////////////////////////////////////////////////////////////////////////////
    // PE opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [overlay_cfg_pkg::OP_WIDTH-1:0] {
        // Result is the sample
        OP_PASS = 2'd0,
        // Sample plus incoming partial
        OP_ADD  = 2'd1,
        // Coefficient times sample
        OP_MUL  = 2'd2,
        // Coefficient times sample plus incoming partial
        OP_MAC  = 2'd3
    } pe_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Frame of samples
    ////////////////////////////////////////////////////////////////////////////

    // Element i belongs to PE i
    typedef cplx_t [overlay_cfg_pkg::PE_NUM-1:0] frame_t;

endpackage

//--- sipo_frame.sv
`timescale 1ns/1ps

module sipo_frame (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       din_v,
    input  overlay_types_pkg::cplx_t   din,
    input  logic                       alpha_v,
    output logic                       frame_v,
    output logic                       frame_alpha,
    output overlay_types_pkg::frame_t  frame
);

    // Index of the next beat inside the frame
    logic [overlay_cfg_pkg::BEAT_CNT_WIDTH-1:0] beat_cnt;
    logic                                       last_beat;

    assign last_beat = din_v &&
        (beat_cnt == overlay_cfg_pkg::BEAT_CNT_WIDTH'(overlay_cfg_pkg::PE_NUM - 1));

    // Beat counter and frame strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt    <= '0;
            frame_v     <= 1'b0;
            frame_alpha <= 1'b0;
        end else begin
            frame_v <= last_beat;
            if (last_beat) begin
                beat_cnt    <= '0;
                // Coefficient tag taken with the closing beat
                frame_alpha <= alpha_v;
            end else if (din_v) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Frame storage, beat k lands in element k
    always_ff @(posedge clk) begin
        if (din_v) begin
            frame[beat_cnt] <= din;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // A frame needs PE_NUM beats, so strobes can never be adjacent
    frame_v_spacing: assert property (
        @(posedge clk) disable iff (rst)
        frame_v |=> !frame_v
    );

endmodule

//--- pe.sv
`timescale 1ns/1ps

module pe #(
    parameter bit CHAIN_HEAD = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_v,
    input  overlay_types_pkg::pe_op_e  op,
    input  logic                       frame_v,
    input  logic                       frame_alpha,
    input  overlay_types_pkg::cplx_t   x,
    input  logic                       tx_v,
    input  overlay_types_pkg::cplx_t   tx,
    output logic                       res_v,
    output overlay_types_pkg::cplx_t   res
);

    overlay_types_pkg::pe_op_e op_r;
    overlay_types_pkg::cplx_t  coef;
    overlay_types_pkg::cplx_t  term;
    overlay_types_pkg::cplx_t  prod;
    overlay_types_pkg::cplx_t  partial;
    logic                      pending;
    logic                      load_term;
    logic                      combine;
    logic                      use_prod;
    logic                      use_partial;

    // Full precision parts, one extra bit for the sum of two products
    logic signed [2*overlay_cfg_pkg::DATA_WIDTH:0] prod_re_full;
    logic signed [2*overlay_cfg_pkg::DATA_WIDTH:0] prod_im_full;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction and coefficient registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op_r <= overlay_types_pkg::OP_PASS;
            coef <= '0;
        end else begin
            if (inst_v) begin
                op_r <= op;
            end
            if (frame_v && frame_alpha) begin
                coef <= x;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Local term
    ////////////////////////////////////////////////////////////////////////////

    // Complex product coef * x
    always_comb begin
        prod_re_full = coef.re * x.re - coef.im * x.im;
        prod_im_full = coef.re * x.im + coef.im * x.re;
        // Arithmetic shift by FRAC_BITS, keep the low DATA_WIDTH bits
        prod.re = prod_re_full[overlay_cfg_pkg::FRAC_BITS +: overlay_cfg_pkg::DATA_WIDTH];
        prod.im = prod_im_full[overlay_cfg_pkg::FRAC_BITS +: overlay_cfg_pkg::DATA_WIDTH];
    end

    assign use_prod = (op_r == overlay_types_pkg::OP_MUL) ||
                      (op_r == overlay_types_pkg::OP_MAC);

    assign use_partial = (op_r == overlay_types_pkg::OP_ADD) ||
                         (op_r == overlay_types_pkg::OP_MAC);

    assign load_term = frame_v && !frame_alpha;

    always_ff @(posedge clk) begin
        if (load_term) begin
            term <= use_prod ? prod : x;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Chain link
    ////////////////////////////////////////////////////////////////////////////

    // Head of chain starts from a zero partial one cycle after its term
    assign combine = CHAIN_HEAD ? pending : tx_v;
    assign partial = CHAIN_HEAD ? '0 : tx;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            res_v   <= 1'b0;
        end else begin
            res_v <= combine;
            // A new term may arrive on the edge that consumes the old one
            if (load_term) begin
                pending <= 1'b1;
            end else if (combine) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (combine) begin
            if (use_partial) begin
                // Both parts wrap modulo 2^16
                res.re <= term.re + partial.re;
                res.im <= term.im + partial.im;
            end else begin
                res <= term;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Upstream partial must meet a term of the same frame
    tx_needs_term: assert property (
        @(posedge clk) disable iff (rst)
        tx_v |-> pending
    );

endmodule

//--- result_piso.sv
`timescale 1ns/1ps

module result_piso (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [overlay_cfg_pkg::PE_NUM-1:0]   res_v,
    input  overlay_types_pkg::frame_t            res,
    output logic                                 dout_v,
    output overlay_types_pkg::cplx_t             dout
);

    overlay_types_pkg::cplx_t [overlay_cfg_pkg::PE_NUM-2:0] slots;
    overlay_types_pkg::frame_t                              shreg;
    logic                                                   load;

    // Wide enough to hold PE_NUM itself
    logic [overlay_cfg_pkg::BEAT_CNT_WIDTH:0] remain;

    // Last PE finishing closes the frame
    assign load = res_v[overlay_cfg_pkg::PE_NUM-1];

    // Result slots of all PEs but the last
    always_ff @(posedge clk) begin
        for (int k = 0; k < overlay_cfg_pkg::PE_NUM - 1; k++) begin
            if (res_v[k]) begin
                slots[k] <= res[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Serial output
    ////////////////////////////////////////////////////////////////////////////

    // Last slot is taken straight from the PE as it arrives
    always_ff @(posedge clk) begin
        if (load) begin
            for (int k = 0; k < overlay_cfg_pkg::PE_NUM - 1; k++) begin
                shreg[k] <= slots[k];
            end
            shreg[overlay_cfg_pkg::PE_NUM-1] <= res[overlay_cfg_pkg::PE_NUM-1];
        end else if (dout_v) begin
            for (int k = 0; k < overlay_cfg_pkg::PE_NUM - 1; k++) begin
                shreg[k] <= shreg[k+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else if (load) begin
            remain <= (overlay_cfg_pkg::BEAT_CNT_WIDTH + 1)'(overlay_cfg_pkg::PE_NUM);
        end else if (dout_v) begin
            remain <= remain - 1'b1;
        end
    end

    assign dout_v = (remain != '0);
    assign dout   = shreg[0];

    // Chain delivers one PE result per cycle
    res_v_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(res_v)
    );

    // New frame must not cut into the one being shifted out
    load_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        load |-> (remain <= 1)
    );

endmodule

//--- overlay.sv
`timescale 1ns/1ps

module overlay (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   din_v,
    input  overlay_types_pkg::cplx_t               din,
    input  logic                                   alpha_v,
    input  logic                                   inst_v,
    input  logic [overlay_cfg_pkg::INST_WIDTH-1:0] inst,
    output logic                                   dout_v,
    output overlay_types_pkg::cplx_t               dout
);

    // Frame broadcast
    logic                      frame_v;
    logic                      frame_alpha;
    overlay_types_pkg::frame_t frame;

    // Per PE results that also feed the next PE
    logic [overlay_cfg_pkg::PE_NUM-1:0] res_v;
    overlay_types_pkg::frame_t          res;

    // Chain link i feeds PE i and link 0 stays idle for the head
    logic [overlay_cfg_pkg::PE_NUM-1:0] chain_v;
    overlay_types_pkg::frame_t          chain;

    assign chain_v = {res_v[overlay_cfg_pkg::PE_NUM-2:0], 1'b0};
    assign chain   = {res[overlay_cfg_pkg::PE_NUM-2:0], overlay_types_pkg::cplx_t'('0)};

    ////////////////////////////////////////////////////////////////////////////
    // Input buffer
    ////////////////////////////////////////////////////////////////////////////

    sipo_frame in_buffer (
        .clk         (clk),
        .rst         (rst),
        .din_v       (din_v),
        .din         (din),
        .alpha_v     (alpha_v),
        .frame_v     (frame_v),
        .frame_alpha (frame_alpha),
        .frame       (frame)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PE chain
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < overlay_cfg_pkg::PE_NUM; i++) begin : array
        overlay_types_pkg::pe_op_e op_sel;

        assign op_sel = overlay_types_pkg::pe_op_e'(
            inst[i*overlay_cfg_pkg::OP_WIDTH +: overlay_cfg_pkg::OP_WIDTH]);

        pe #(
            .CHAIN_HEAD (i == 0)
        ) u_pe (
            .clk         (clk),
            .rst         (rst),
            .inst_v      (inst_v),
            .op          (op_sel),
            .frame_v     (frame_v),
            .frame_alpha (frame_alpha),
            .x           (frame[i]),
            .tx_v        (chain_v[i]),
            .tx          (chain[i]),
            .res_v       (res_v[i]),
            .res         (res[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output buffer
    ////////////////////////////////////////////////////////////////////////////

    result_piso out_buffer (
        .clk    (clk),
        .rst    (rst),
        .res_v  (res_v),
        .res    (res),
        .dout_v (dout_v),
        .dout   (dout)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb_overlay.sv
`timescale 1ns/1ps

module tb_overlay;

    // Longest latency of one frame plus margin
    localparam int FRAME_CYCLES    = 2 * overlay_cfg_pkg::PE_NUM + 4;
    localparam int RANDOM_FRAMES   = 50;
    localparam int ROUNDS          = 6;
    localparam int ROUND_FRAMES    = 3;
    localparam int TOTAL_FRAMES    = 4 + RANDOM_FRAMES + ROUNDS * (ROUND_FRAMES + 1);
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_FRAMES * FRAME_CYCLES;

    logic                                   clk;
    logic                                   rst;
    logic                                   din_v;
    overlay_types_pkg::cplx_t               din;
    logic                                   alpha_v;
    logic                                   inst_v;
    logic [overlay_cfg_pkg::INST_WIDTH-1:0] inst;
    logic                                   dout_v;
    overlay_types_pkg::cplx_t               dout;

    // Testbench copy of the PE state
    overlay_types_pkg::frame_t              coef_model;
    logic [overlay_cfg_pkg::INST_WIDTH-1:0] inst_model;
    overlay_types_pkg::frame_t              exp_q[$];

    integer                    seed;
    int                        errors;
    int                        err_mark;
    int                        checks;
    int                        test_num;
    int                        beats_seen;
    int                        frames_sent;
    int                        beat_idx;
    bit                        have_exp;
    overlay_types_pkg::frame_t cur_exp;

    tb_clk_gen clk_gen (
        .clk (clk),
        .rst (rst)
    );

    overlay i_overlay (
        .clk     (clk),
        .rst     (rst),
        .din_v   (din_v),
        .din     (din),
        .alpha_v (alpha_v),
        .inst_v  (inst_v),
        .inst    (inst),
        .dout_v  (dout_v),
        .dout    (dout)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic overlay_types_pkg::cplx_t cplx_add(
        input overlay_types_pkg::cplx_t a,
        input overlay_types_pkg::cplx_t b
    );
        overlay_types_pkg::cplx_t r;
        // Wraps to 16 bits on assignment
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

    function automatic overlay_types_pkg::cplx_t cplx_mul(
        input overlay_types_pkg::cplx_t a,
        input overlay_types_pkg::cplx_t b
    );
        longint                   pr;
        longint                   pi;
        overlay_types_pkg::cplx_t r;
        pr = longint'($signed(a.re)) * longint'($signed(b.re))
           - longint'($signed(a.im)) * longint'($signed(b.im));
        pi = longint'($signed(a.re)) * longint'($signed(b.im))
           + longint'($signed(a.im)) * longint'($signed(b.re));
        r.re = 16'(pr >>> overlay_cfg_pkg::FRAC_BITS);
        r.im = 16'(pi >>> overlay_cfg_pkg::FRAC_BITS);
        return r;
    endfunction

    // Expected results of PE 0 upward with each one feeding the next
    function automatic overlay_types_pkg::frame_t ref_frame(
        input overlay_types_pkg::frame_t              x,
        input overlay_types_pkg::frame_t              c,
        input logic [overlay_cfg_pkg::INST_WIDTH-1:0] ins
    );
        overlay_types_pkg::frame_t exp_res;
        overlay_types_pkg::cplx_t  partial;
        overlay_types_pkg::cplx_t  term;
        overlay_types_pkg::pe_op_e op;
        partial = '0;
        for (int i = 0; i < overlay_cfg_pkg::PE_NUM; i++) begin
            op = overlay_types_pkg::pe_op_e'(
                ins[i*overlay_cfg_pkg::OP_WIDTH +: overlay_cfg_pkg::OP_WIDTH]);
            if (op == overlay_types_pkg::OP_MUL || op == overlay_types_pkg::OP_MAC) begin
                term = cplx_mul(c[i], x[i]);
            end else begin
                term = x[i];
            end
            if (op == overlay_types_pkg::OP_ADD || op == overlay_types_pkg::OP_MAC) begin
                exp_res[i] = cplx_add(term, partial);
            end else begin
                exp_res[i] = term;
            end
            partial = exp_res[i];
        end
        return exp_res;
    endfunction

    function automatic overlay_types_pkg::frame_t random_frame();
        overlay_types_pkg::frame_t f;
        for (int k = 0; k < overlay_cfg_pkg::PE_NUM; k++) begin
            f[k] = $random(seed);
        end
        return f;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            din_v   <= 1'b0;
            alpha_v <= 1'b0;
            inst_v  <= 1'b0;
        end
    endtask

    // Beats go out one per cycle and din_v stays high for the caller
    task automatic send_frame(input overlay_types_pkg::frame_t f, input bit is_coef);
        for (int k = 0; k < overlay_cfg_pkg::PE_NUM; k++) begin
            @(posedge clk);
            din_v   <= 1'b1;
            din     <= f[k];
            alpha_v <= is_coef;
            inst_v  <= 1'b0;
        end
        if (is_coef) begin
            coef_model = f;
        end else begin
            exp_q.push_back(ref_frame(f, coef_model, inst_model));
            frames_sent++;
        end
    endtask

    task automatic load_inst(input logic [overlay_cfg_pkg::INST_WIDTH-1:0] ins);
        @(posedge clk);
        din_v   <= 1'b0;
        alpha_v <= 1'b0;
        inst_v  <= 1'b1;
        inst    <= ins;
        @(posedge clk);
        inst_v  <= 1'b0;
        inst_model = ins;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || beat_idx != 0) && waited < 2 * FRAME_CYCLES) begin
            idle_cycles(1);
            waited++;
        end
        assert (exp_q.size() == 0 && beat_idx == 0) else begin
            $display("Expected output frames did not arrive, %0d still pending",
                     exp_q.size());
            errors++;
            exp_q.delete();
        end
        idle_cycles(overlay_cfg_pkg::PE_NUM);
    endtask

    task automatic finish_test(input string name);
        test_num++;
        $display("Test %0d %s: %s, %0d errors", test_num, name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output compare
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            beat_idx = 0;
        end else if (dout_v === 1'b1) begin
            if (beat_idx == 0) begin
                have_exp = (exp_q.size() != 0);
                assert (have_exp) else begin
                    $display("Output beat arrived while no frame was expected");
                    errors++;
                end
                if (have_exp) begin
                    cur_exp = exp_q.pop_front();
                end
            end
            if (have_exp) begin
                checks++;
                assert (dout === cur_exp[beat_idx]) else begin
                    $display("FAILED dout beat %0d: expected %h, got %h",
                             beat_idx, cur_exp[beat_idx], dout);
                    errors++;
                end
            end
            beats_seen++;
            beat_idx = (beat_idx == overlay_cfg_pkg::PE_NUM - 1) ? 0 : beat_idx + 1;
        end else begin
            assert (beat_idx == 0) else begin
                $display("Output frame stopped after %0d of %0d beats",
                         beat_idx, overlay_cfg_pkg::PE_NUM);
                errors++;
                beat_idx = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        overlay_types_pkg::frame_t f;
        int                        beats_before;
        seed        = 40882;
        errors      = 0;
        err_mark    = 0;
        checks      = 0;
        test_num    = 0;
        beats_seen  = 0;
        frames_sent = 0;
        beat_idx    = 0;
        have_exp    = 1'b0;
        coef_model  = '0;
        inst_model  = '0;
        din_v   <= 1'b0;
        din     <= '0;
        alpha_v <= 1'b0;
        inst_v  <= 1'b0;
        inst    <= '0;
        @(negedge rst);

        // Quiet output and then pass-through with opcodes from reset
        repeat (20) begin
            @(negedge clk);
            assert (dout_v === 1'b0) else begin
                $display("FAILED dout_v: expected %h, got %h", 1'b0, dout_v);
                errors++;
            end
        end
        f[0] = {16'h1111, 16'h2222};
        f[1] = {16'h3333, 16'h4444};
        f[2] = {16'h8001, 16'h7ffe};
        f[3] = {16'hfedc, 16'h0123};
        send_frame(f, 1'b0);
        wait_drained();
        finish_test("reset and pass");

        // Running sums that wrap near full scale
        load_inst({4{overlay_types_pkg::OP_ADD}});
        f[0] = {16'h7ff0, 16'h8001};
        f[1] = {16'h0020, 16'hfff0};
        f[2] = {16'h7000, 16'h8000};
        f[3] = {16'h9000, 16'h1234};
        send_frame(f, 1'b0);
        wait_drained();
        finish_test("chain add");

        // Coefficients 0.5, 0.5j, -1 and about 0.707-0.707j
        f[0] = {16'h4000, 16'h0000};
        f[1] = {16'h0000, 16'h4000};
        f[2] = {16'h8000, 16'h0000};
        f[3] = {16'h5a82, 16'ha57e};
        beats_before = beats_seen;
        send_frame(f, 1'b1);
        idle_cycles(FRAME_CYCLES);
        assert (beats_seen == beats_before) else begin
            $display("Coefficient frame produced %0d output beats", beats_seen - beats_before);
            errors++;
        end
        load_inst({4{overlay_types_pkg::OP_MUL}});
        f[0] = {16'h2000, 16'hc000};
        f[1] = {16'h7fff, 16'h8000};
        f[2] = {16'h1234, 16'hedcc};
        f[3] = {16'hc000, 16'h4000};
        send_frame(f, 1'b0);
        wait_drained();
        finish_test("coefficients and multiply");

        // PE 0 to PE 3 run PASS, MAC, ADD, MAC on back to back frames
        load_inst({overlay_types_pkg::OP_MAC, overlay_types_pkg::OP_ADD,
                   overlay_types_pkg::OP_MAC, overlay_types_pkg::OP_PASS});
        beats_before = beats_seen;
        for (int n = 0; n < RANDOM_FRAMES; n++) begin
            send_frame(random_frame(), 1'b0);
        end
        wait_drained();
        assert (beats_seen - beats_before == RANDOM_FRAMES * overlay_cfg_pkg::PE_NUM) else begin
            $display("FAILED dout beat count: expected %h, got %h",
                     RANDOM_FRAMES * overlay_cfg_pkg::PE_NUM, beats_seen - beats_before);
            errors++;
        end
        finish_test("mixed stream");

        for (int r = 0; r < ROUNDS; r++) begin
            load_inst(overlay_cfg_pkg::INST_WIDTH'($random(seed)));
            send_frame(random_frame(), 1'b1);
            for (int n = 0; n < ROUND_FRAMES; n++) begin
                send_frame(random_frame(), 1'b0);
            end
            wait_drained();
        end
        assert (beats_seen == frames_sent * overlay_cfg_pkg::PE_NUM) else begin
            $display("FAILED dout beat count: expected %h, got %h",
                     frames_sent * overlay_cfg_pkg::PE_NUM, beats_seen);
            errors++;
        end
        finish_test("reconfiguration");

        $display("Checks %0d, errors %0d, output beats %0d, data frames %0d",
                 checks, errors, beats_seen, frames_sent);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
overlay_cfg_pkg.sv
overlay_types_pkg.sv
sipo_frame.sv
pe.sv
result_piso.sv
overlay.sv
tb_clk_gen.sv
tb_overlay.sv
